//--- sim.f
+incdir+include
hw/mem_pkg.sv
hw/axi_sram.sv
hw/axi_arbiter.sv
hw/fetch_port.sv
hw/lsu_port.sv
hw/mem_subsys_top.sv
verification/tb_mem_subsys.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_mem_subsys
FILELIST  = sim.f
PASS_MSG  = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- verification/tb_mem_subsys.sv
// Memory subsystem testbench
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_mem_subsys;

  localparam int TIMEOUT  = 200;
  localparam int NUM_ROWS = 18;
  localparam mem_pkg::master_e PORT_IF = mem_pkg::M_FETCH;
  localparam mem_pkg::master_e PORT_LS = mem_pkg::M_LSU;

  typedef struct packed {
    mem_pkg::master_e       port;
    logic                   we;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] wdata;
    logic [`MEM_STRB_W-1:0] strb;
    logic                   conc;
    logic [3:0]             hold;
  } row_t;

  logic                   i_aclk;
  logic                   i_arst_n;
  logic                   i_if_req_valid;
  logic                   o_if_req_ready;
  logic [`MEM_ADDR_W-1:0] i_if_addr;
  logic                   o_if_rsp_valid;
  logic                   i_if_rsp_ready;
  logic [`MEM_DATA_W-1:0] o_if_rdata;
  logic                   o_if_err;
  logic                   i_ls_req_valid;
  logic                   o_ls_req_ready;
  logic                   i_ls_we;
  logic [`MEM_ADDR_W-1:0] i_ls_addr;
  logic [`MEM_DATA_W-1:0] i_ls_wdata;
  logic [`MEM_STRB_W-1:0] i_ls_wstrb;
  logic                   o_ls_rsp_valid;
  logic                   i_ls_rsp_ready;
  logic [`MEM_DATA_W-1:0] o_ls_rdata;
  logic                   o_ls_err;

  // Byte-wide reference memory
  logic [7:0] model_mem [`MEM_DEPTH*8];

  // Concurrent rows also fetch the neighbouring doubleword (addr ^ 8)
  row_t rows [NUM_ROWS] = '{
    '{PORT_LS, 1'b1, 32'h0000_0000, 64'h1122_3344_5566_7788, 8'hff, 1'b0, 4'd0},
    '{PORT_LS, 1'b1, 32'h0000_0008, 64'h0123_4567_89ab_cdef, 8'hff, 1'b0, 4'd0},
    '{PORT_LS, 1'b1, 32'h0000_0000, 64'haaaa_aaaa_aaaa_aaaa, 8'h0f, 1'b0, 4'd0},
    '{PORT_LS, 1'b1, 32'h0000_0000, 64'hbbbb_bbbb_bbbb_bbbb, 8'h30, 1'b0, 4'd2},
    '{PORT_LS, 1'b0, 32'h0000_0000, 64'h0,                   8'h00, 1'b0, 4'd3},
    '{PORT_IF, 1'b0, 32'h0000_0000, 64'h0,                   8'h00, 1'b0, 4'd0},
    '{PORT_LS, 1'b1, 32'h0000_07f8, 64'hcafe_f00d_1234_5678, 8'hff, 1'b0, 4'd0},
    '{PORT_LS, 1'b1, 32'h0000_0800, 64'hffff_ffff_ffff_ffff, 8'hff, 1'b0, 4'd1},
    '{PORT_LS, 1'b0, 32'h0000_0000, 64'h0,                   8'h00, 1'b0, 4'd0},
    '{PORT_LS, 1'b0, 32'h0000_07f8, 64'h0,                   8'h00, 1'b0, 4'd0},
    '{PORT_LS, 1'b0, 32'h0000_0800, 64'h0,                   8'h00, 1'b0, 4'd2},
    '{PORT_IF, 1'b0, 32'h0000_1000, 64'h0,                   8'h00, 1'b0, 4'd4},
    '{PORT_LS, 1'b1, 32'h0000_0010, 64'h0f1e_2d3c_4b5a_6978, 8'hff, 1'b0, 4'd0},
    '{PORT_LS, 1'b1, 32'h0000_0018, 64'h5555_aaaa_5555_aaaa, 8'hff, 1'b1, 4'd3},
    '{PORT_LS, 1'b0, 32'h0000_0018, 64'h0,                   8'h00, 1'b1, 4'd5},
    '{PORT_IF, 1'b0, 32'h0000_0018, 64'h0,                   8'h00, 1'b0, 4'd6},
    '{PORT_LS, 1'b0, 32'h0000_0808, 64'h0,                   8'h00, 1'b1, 4'd2},
    '{PORT_LS, 1'b0, 32'h0000_0008, 64'h0,                   8'h00, 1'b1, 4'd7}
  };

  mem_subsys_top DUT (.*);

  initial begin
    i_aclk = 1'b0;
    forever #5 i_aclk = ~i_aclk;
  end

  // --------------------
  // Reference model
  function automatic logic in_range(input logic [`MEM_ADDR_W-1:0] addr);
    return addr < 32'(`MEM_DEPTH * 8);
  endfunction

  function automatic logic [`MEM_DATA_W-1:0] model_read(input logic [`MEM_ADDR_W-1:0] addr);
    logic [`MEM_DATA_W-1:0] data;
    int base;
    data = '0;
    base = int'({addr[10:3], 3'b000});
    if (in_range(addr)) begin
      for (int b = 0; b < `MEM_STRB_W; b++) begin
        data[b*8 +: 8] = model_mem[base + b];
      end
    end
    return data;
  endfunction

  task automatic model_write(input logic [`MEM_ADDR_W-1:0] addr,
                             input logic [`MEM_DATA_W-1:0] data,
                             input logic [`MEM_STRB_W-1:0] strb);
    int base;
    base = int'({addr[10:3], 3'b000});
    for (int b = 0; b < `MEM_STRB_W; b++) begin
      if (strb[b]) begin
        model_mem[base + b] = data[b*8 +: 8];
      end
    end
  endtask

  // --------------------
  // Checks
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("tests failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      stop_run($sformatf("ERR t=%0t %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic run_fetch(input logic [`MEM_ADDR_W-1:0] addr, input int hold,
                           input logic [`MEM_DATA_W-1:0] exp_data, input logic exp_err);
    int cnt;
    int gap;
    logic [`MEM_DATA_W-1:0] seen_data;
    logic seen_err;
    @(posedge i_aclk);
    i_if_req_valid <= 1'b1;
    i_if_addr      <= addr;
    cnt = 0;
    @(negedge i_aclk);
    while (!o_if_req_ready) begin
      cnt++;
      if (cnt > TIMEOUT) stop_run("Fetch request was never accepted");
      @(negedge i_aclk);
    end
    @(posedge i_aclk);
    i_if_req_valid <= 1'b0;
    cnt = 0;
    @(negedge i_aclk);
    while (!o_if_rsp_valid) begin
      cnt++;
      if (cnt > TIMEOUT) stop_run("Fetch response never arrived");
      @(negedge i_aclk);
    end
    seen_data = o_if_rdata;
    seen_err  = o_if_err;
    check_val("o_if_rdata", exp_data, seen_data);
    check_val("o_if_err", 64'(exp_err), 64'(seen_err));
    // Back-pressure, response must hold
    gap = int'($urandom_range(hold, 0));
    repeat (gap) begin
      @(negedge i_aclk);
      check_val("o_if_rsp_valid", 64'(1), 64'(o_if_rsp_valid));
      check_val("o_if_rdata", seen_data, o_if_rdata);
      check_val("o_if_err", 64'(seen_err), 64'(o_if_err));
      check_val("o_if_req_ready", 64'(0), 64'(o_if_req_ready));
    end
    @(posedge i_aclk);
    i_if_rsp_ready <= 1'b1;
    @(posedge i_aclk);
    i_if_rsp_ready <= 1'b0;
  endtask

  task automatic run_lsu(input logic we, input logic [`MEM_ADDR_W-1:0] addr,
                         input logic [`MEM_DATA_W-1:0] wdata,
                         input logic [`MEM_STRB_W-1:0] strb, input int hold,
                         input logic [`MEM_DATA_W-1:0] exp_data, input logic exp_err);
    int cnt;
    int gap;
    logic [`MEM_DATA_W-1:0] seen_data;
    logic seen_err;
    @(posedge i_aclk);
    i_ls_req_valid <= 1'b1;
    i_ls_we        <= we;
    i_ls_addr      <= addr;
    i_ls_wdata     <= wdata;
    i_ls_wstrb     <= strb;
    cnt = 0;
    @(negedge i_aclk);
    while (!o_ls_req_ready) begin
      cnt++;
      if (cnt > TIMEOUT) stop_run("LSU request was never accepted");
      @(negedge i_aclk);
    end
    @(posedge i_aclk);
    i_ls_req_valid <= 1'b0;
    cnt = 0;
    @(negedge i_aclk);
    while (!o_ls_rsp_valid) begin
      cnt++;
      if (cnt > TIMEOUT) stop_run("LSU response never arrived");
      @(negedge i_aclk);
    end
    seen_data = o_ls_rdata;
    seen_err  = o_ls_err;
    check_val("o_ls_rdata", exp_data, seen_data);
    check_val("o_ls_err", 64'(exp_err), 64'(seen_err));
    gap = int'($urandom_range(hold, 0));
    repeat (gap) begin
      @(negedge i_aclk);
      check_val("o_ls_rsp_valid", 64'(1), 64'(o_ls_rsp_valid));
      check_val("o_ls_rdata", seen_data, o_ls_rdata);
      check_val("o_ls_err", 64'(seen_err), 64'(o_ls_err));
      check_val("o_ls_req_ready", 64'(0), 64'(o_ls_req_ready));
    end
    @(posedge i_aclk);
    i_ls_rsp_ready <= 1'b1;
    @(posedge i_aclk);
    i_ls_rsp_ready <= 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    logic [`MEM_ADDR_W-1:0] f_addr;
    logic [`MEM_DATA_W-1:0] f_data;
    logic [`MEM_DATA_W-1:0] l_data;
    logic                   f_err;
    logic                   l_err;
    f_addr = r.conc ? (r.addr ^ 32'h8) : r.addr;
    f_data = model_read(f_addr);
    f_err  = !in_range(f_addr);
    l_data = r.we ? '0 : model_read(r.addr);
    l_err  = !in_range(r.addr);
    if (r.conc) begin
      fork
        run_fetch(f_addr, int'(r.hold), f_data, f_err);
        run_lsu(r.we, r.addr, r.wdata, r.strb, int'(r.hold), l_data, l_err);
      join
    end else if (r.port == PORT_IF) begin
      run_fetch(f_addr, int'(r.hold), f_data, f_err);
    end else begin
      run_lsu(r.we, r.addr, r.wdata, r.strb, int'(r.hold), l_data, l_err);
    end
    // Out-of-range stores leave memory untouched
    if (r.we && !l_err) begin
      model_write(r.addr, r.wdata, r.strb);
    end
  endtask

  // --------------------
  // Main sequence
  initial begin
    void'($urandom(32'h22f7762f));
    i_arst_n       = 1'b0;
    i_if_req_valid = 1'b0;
    i_if_addr      = '0;
    i_if_rsp_ready = 1'b0;
    i_ls_req_valid = 1'b0;
    i_ls_we        = 1'b0;
    i_ls_addr      = '0;
    i_ls_wdata     = '0;
    i_ls_wstrb     = '0;
    i_ls_rsp_ready = 1'b0;
    repeat (16) @(posedge i_aclk);
    i_arst_n <= 1'b1;
    @(negedge i_aclk);
    check_val("o_if_rsp_valid", 64'(0), 64'(o_if_rsp_valid));
    check_val("o_ls_rsp_valid", 64'(0), 64'(o_ls_rsp_valid));
    check_val("o_if_req_ready", 64'(1), 64'(o_if_req_ready));
    check_val("o_ls_req_ready", 64'(1), 64'(o_ls_req_ready));
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i]);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

//--- hw/mem_subsys_top.sv
// Memory subsystem top
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_subsys_top (
  input  logic                   i_aclk,
  input  logic                   i_arst_n,
  // Fetch
  input  logic                   i_if_req_valid,
  output logic                   o_if_req_ready,
  input  logic [`MEM_ADDR_W-1:0] i_if_addr,
  output logic                   o_if_rsp_valid,
  input  logic                   i_if_rsp_ready,
  output logic [`MEM_DATA_W-1:0] o_if_rdata,
  output logic                   o_if_err,
  // Load/store
  input  logic                   i_ls_req_valid,
  output logic                   o_ls_req_ready,
  input  logic                   i_ls_we,
  input  logic [`MEM_ADDR_W-1:0] i_ls_addr,
  input  logic [`MEM_DATA_W-1:0] i_ls_wdata,
  input  logic [`MEM_STRB_W-1:0] i_ls_wstrb,
  output logic                   o_ls_rsp_valid,
  input  logic                   i_ls_rsp_ready,
  output logic [`MEM_DATA_W-1:0] o_ls_rdata,
  output logic                   o_ls_err
);

  // Fetch master, read only
  logic [`MEM_ID_W-1:0]   m0_arid;
  logic [`MEM_ADDR_W-1:0] m0_araddr;
  logic [`MEM_DATA_W-1:0] m0_rdata;
  mem_pkg::axi_resp_e     m0_rresp;
  logic                   m0_arvalid, m0_arready, m0_rvalid, m0_rready;

  // Load/store master
  logic [`MEM_ID_W-1:0]   m1_awid, m1_arid;
  logic [`MEM_ADDR_W-1:0] m1_awaddr, m1_araddr;
  logic [`MEM_DATA_W-1:0] m1_wdata, m1_rdata;
  logic [`MEM_STRB_W-1:0] m1_wstrb;
  mem_pkg::axi_resp_e     m1_bresp, m1_rresp;
  logic                   m1_awvalid, m1_awready, m1_wvalid, m1_wready, m1_bvalid, m1_bready;
  logic                   m1_arvalid, m1_arready, m1_rvalid, m1_rready;

  // SRAM slave
  logic [`MEM_ID_W-1:0]   s_awid, s_bid, s_arid, s_rid;
  logic [`MEM_ADDR_W-1:0] s_awaddr, s_araddr;
  logic [`MEM_DATA_W-1:0] s_wdata, s_rdata;
  logic [`MEM_STRB_W-1:0] s_wstrb;
  mem_pkg::axi_resp_e     s_bresp, s_rresp;
  logic                   s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic                   s_arvalid, s_arready, s_rvalid, s_rready, s_rlast;

  fetch_port u_fetch (
    .i_aclk (i_aclk), .i_arst_n (i_arst_n),
    .i_if_req_valid (i_if_req_valid), .o_if_req_ready (o_if_req_ready),
    .i_if_addr (i_if_addr), .o_if_rsp_valid (o_if_rsp_valid),
    .i_if_rsp_ready (i_if_rsp_ready), .o_if_rdata (o_if_rdata), .o_if_err (o_if_err),
    .o_arid (m0_arid), .o_araddr (m0_araddr), .o_arvalid (m0_arvalid),
    .i_arready (m0_arready), .i_rdata (m0_rdata), .i_rresp (m0_rresp),
    .i_rvalid (m0_rvalid), .o_rready (m0_rready)
  );

  lsu_port u_lsu (
    .i_aclk (i_aclk), .i_arst_n (i_arst_n),
    .i_ls_req_valid (i_ls_req_valid), .o_ls_req_ready (o_ls_req_ready),
    .i_ls_we (i_ls_we), .i_ls_addr (i_ls_addr), .i_ls_wdata (i_ls_wdata),
    .i_ls_wstrb (i_ls_wstrb), .o_ls_rsp_valid (o_ls_rsp_valid),
    .i_ls_rsp_ready (i_ls_rsp_ready), .o_ls_rdata (o_ls_rdata), .o_ls_err (o_ls_err),
    .o_awid (m1_awid), .o_awaddr (m1_awaddr), .o_awvalid (m1_awvalid),
    .i_awready (m1_awready), .o_wdata (m1_wdata), .o_wstrb (m1_wstrb),
    .o_wvalid (m1_wvalid), .i_wready (m1_wready), .i_bresp (m1_bresp),
    .i_bvalid (m1_bvalid), .o_bready (m1_bready), .o_arid (m1_arid),
    .o_araddr (m1_araddr), .o_arvalid (m1_arvalid), .i_arready (m1_arready),
    .i_rdata (m1_rdata), .i_rresp (m1_rresp), .i_rvalid (m1_rvalid), .o_rready (m1_rready)
  );

  // No write channel on the fetch side
  axi_arbiter u_arbiter (
    .i_aclk (i_aclk), .i_arst_n (i_arst_n),
    .i_m0_awid ('0), .i_m0_awaddr ('0), .i_m0_awvalid (1'b0), .o_m0_awready (),
    .i_m0_wdata ('0), .i_m0_wstrb ('0), .i_m0_wvalid (1'b0), .o_m0_wready (),
    .o_m0_bresp (), .o_m0_bvalid (), .i_m0_bready (1'b0),
    .i_m0_arid (m0_arid), .i_m0_araddr (m0_araddr), .i_m0_arvalid (m0_arvalid),
    .o_m0_arready (m0_arready), .o_m0_rdata (m0_rdata), .o_m0_rresp (m0_rresp),
    .o_m0_rvalid (m0_rvalid), .i_m0_rready (m0_rready),
    .i_m1_awid (m1_awid), .i_m1_awaddr (m1_awaddr), .i_m1_awvalid (m1_awvalid),
    .o_m1_awready (m1_awready), .i_m1_wdata (m1_wdata), .i_m1_wstrb (m1_wstrb),
    .i_m1_wvalid (m1_wvalid), .o_m1_wready (m1_wready), .o_m1_bresp (m1_bresp),
    .o_m1_bvalid (m1_bvalid), .i_m1_bready (m1_bready),
    .i_m1_arid (m1_arid), .i_m1_araddr (m1_araddr), .i_m1_arvalid (m1_arvalid),
    .o_m1_arready (m1_arready), .o_m1_rdata (m1_rdata), .o_m1_rresp (m1_rresp),
    .o_m1_rvalid (m1_rvalid), .i_m1_rready (m1_rready),
    .o_s_awid (s_awid), .o_s_awaddr (s_awaddr), .o_s_awvalid (s_awvalid),
    .i_s_awready (s_awready), .o_s_wdata (s_wdata), .o_s_wstrb (s_wstrb),
    .o_s_wvalid (s_wvalid), .i_s_wready (s_wready), .i_s_bid (s_bid),
    .i_s_bresp (s_bresp), .i_s_bvalid (s_bvalid), .o_s_bready (s_bready),
    .o_s_arid (s_arid), .o_s_araddr (s_araddr), .o_s_arvalid (s_arvalid),
    .i_s_arready (s_arready), .i_s_rid (s_rid), .i_s_rdata (s_rdata),
    .i_s_rresp (s_rresp), .i_s_rlast (s_rlast), .i_s_rvalid (s_rvalid),
    .o_s_rready (s_rready)
  );

  axi_sram u_sram (
    .i_aclk (i_aclk), .i_arst_n (i_arst_n),
    .i_awid (s_awid), .i_awaddr (s_awaddr), .i_awvalid (s_awvalid), .o_awready (s_awready),
    .i_wdata (s_wdata), .i_wstrb (s_wstrb), .i_wvalid (s_wvalid), .o_wready (s_wready),
    .o_bid (s_bid), .o_bresp (s_bresp), .o_bvalid (s_bvalid), .i_bready (s_bready),
    .i_arid (s_arid), .i_araddr (s_araddr), .i_arvalid (s_arvalid), .o_arready (s_arready),
    .o_rid (s_rid), .o_rdata (s_rdata), .o_rresp (s_rresp), .o_rlast (s_rlast),
    .o_rvalid (s_rvalid), .i_rready (s_rready)
  );

endmodule

//--- hw/lsu_port.sv
// Load/store AXI master
`timescale 1ns/1ps
`include "mem_params.svh"

module lsu_port (
  input  logic                   i_aclk,
  input  logic                   i_arst_n,
  // Core side
  input  logic                   i_ls_req_valid,
  output logic                   o_ls_req_ready,
  input  logic                   i_ls_we,
  input  logic [`MEM_ADDR_W-1:0] i_ls_addr,
  input  logic [`MEM_DATA_W-1:0] i_ls_wdata,
  input  logic [`MEM_STRB_W-1:0] i_ls_wstrb,
  output logic                   o_ls_rsp_valid,
  input  logic                   i_ls_rsp_ready,
  output logic [`MEM_DATA_W-1:0] o_ls_rdata,
  output logic                   o_ls_err,
  // AXI master
  output logic [`MEM_ID_W-1:0]   o_awid,
  output logic [`MEM_ADDR_W-1:0] o_awaddr,
  output logic                   o_awvalid,
  input  logic                   i_awready,
  output logic [`MEM_DATA_W-1:0] o_wdata,
  output logic [`MEM_STRB_W-1:0] o_wstrb,
  output logic                   o_wvalid,
  input  logic                   i_wready,
  input  mem_pkg::axi_resp_e     i_bresp,
  input  logic                   i_bvalid,
  output logic                   o_bready,
  output logic [`MEM_ID_W-1:0]   o_arid,
  output logic [`MEM_ADDR_W-1:0] o_araddr,
  output logic                   o_arvalid,
  input  logic                   i_arready,
  input  logic [`MEM_DATA_W-1:0] i_rdata,
  input  mem_pkg::axi_resp_e     i_rresp,
  input  logic                   i_rvalid,
  output logic                   o_rready
);

  typedef enum logic [2:0] {IDLE, AR, R, AW, W, B, RESP} state_e;

  state_e                 state;
  logic [`MEM_ADDR_W-1:0] addr_q;
  logic [`MEM_DATA_W-1:0] wdata_q;
  logic [`MEM_STRB_W-1:0] wstrb_q;
  logic                   req_fire;

  assign req_fire = i_ls_req_valid & o_ls_req_ready;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (req_fire) state <= i_ls_we ? AW : AR;
        AR:   if (i_arready) state <= R;
        R:    if (i_rvalid) state <= RESP;
        AW:   if (i_awready) state <= W;
        W:    if (i_wready) state <= B;
        B:    if (i_bvalid) state <= RESP;
        RESP: if (i_ls_rsp_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Stores report zero data
  always_ff @(posedge i_aclk) begin
    if (req_fire) begin
      addr_q  <= i_ls_addr;
      wdata_q <= i_ls_wdata;
      wstrb_q <= i_ls_wstrb;
    end
    if (o_rready && i_rvalid) begin
      o_ls_rdata <= i_rdata;
      o_ls_err   <= i_rresp == mem_pkg::RESP_SLVERR;
    end else if (o_bready && i_bvalid) begin
      o_ls_rdata <= '0;
      o_ls_err   <= i_bresp == mem_pkg::RESP_SLVERR;
    end
  end

  assign o_ls_req_ready = state == IDLE;
  assign o_ls_rsp_valid = state == RESP;
  assign o_arid         = `MEM_ID_LSU;
  assign o_awid         = `MEM_ID_LSU;
  assign o_araddr       = addr_q;
  assign o_awaddr       = addr_q;
  assign o_wdata        = wdata_q;
  assign o_wstrb        = wstrb_q;
  assign o_arvalid      = state == AR;
  assign o_rready       = state == R;
  assign o_awvalid      = state == AW;
  assign o_wvalid       = state == W;
  assign o_bready       = state == B;

endmodule

//--- hw/fetch_port.sv
// Instruction fetch read master
`timescale 1ns/1ps
`include "mem_params.svh"

module fetch_port (
  input  logic                   i_aclk,
  input  logic                   i_arst_n,
  // Core side
  input  logic                   i_if_req_valid,
  output logic                   o_if_req_ready,
  input  logic [`MEM_ADDR_W-1:0] i_if_addr,
  output logic                   o_if_rsp_valid,
  input  logic                   i_if_rsp_ready,
  output logic [`MEM_DATA_W-1:0] o_if_rdata,
  output logic                   o_if_err,
  // AXI read master
  output logic [`MEM_ID_W-1:0]   o_arid,
  output logic [`MEM_ADDR_W-1:0] o_araddr,
  output logic                   o_arvalid,
  input  logic                   i_arready,
  input  logic [`MEM_DATA_W-1:0] i_rdata,
  input  mem_pkg::axi_resp_e     i_rresp,
  input  logic                   i_rvalid,
  output logic                   o_rready
);

  typedef enum logic [1:0] {IDLE, BUS, RESP} state_e;

  state_e                 state;
  logic                   ar_pend;
  logic [`MEM_ADDR_W-1:0] addr_q;
  logic                   req_fire, r_fire;

  assign req_fire = i_if_req_valid & o_if_req_ready;
  assign r_fire   = i_rvalid & o_rready;

  // BUS covers both the AR and the R phase
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= IDLE;
      ar_pend <= 1'b0;
    end else begin
      case (state)
        IDLE: if (req_fire) begin
          state   <= BUS;
          ar_pend <= 1'b1;
        end
        BUS: begin
          if (o_arvalid && i_arready) begin
            ar_pend <= 1'b0;
          end
          if (r_fire) begin
            state <= RESP;
          end
        end
        RESP: if (i_if_rsp_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (req_fire) begin
      addr_q <= i_if_addr;
    end
    if (r_fire) begin
      o_if_rdata <= i_rdata;
      o_if_err   <= i_rresp == mem_pkg::RESP_SLVERR;
    end
  end

  assign o_if_req_ready = state == IDLE;
  assign o_if_rsp_valid = state == RESP;
  assign o_arid         = `MEM_ID_FETCH;
  assign o_araddr       = addr_q;
  assign o_arvalid      = ar_pend;
  assign o_rready       = (state == BUS) && !ar_pend;

endmodule

//--- hw/axi_arbiter.sv
// Two-to-one AXI arbiter
`timescale 1ns/1ps
`include "mem_params.svh"

module axi_arbiter (
  input  logic                   i_aclk,
  input  logic                   i_arst_n,
  // Master 0
  input  logic [`MEM_ID_W-1:0]   i_m0_awid,
  input  logic [`MEM_ADDR_W-1:0] i_m0_awaddr,
  input  logic                   i_m0_awvalid,
  output logic                   o_m0_awready,
  input  logic [`MEM_DATA_W-1:0] i_m0_wdata,
  input  logic [`MEM_STRB_W-1:0] i_m0_wstrb,
  input  logic                   i_m0_wvalid,
  output logic                   o_m0_wready,
  output mem_pkg::axi_resp_e     o_m0_bresp,
  output logic                   o_m0_bvalid,
  input  logic                   i_m0_bready,
  input  logic [`MEM_ID_W-1:0]   i_m0_arid,
  input  logic [`MEM_ADDR_W-1:0] i_m0_araddr,
  input  logic                   i_m0_arvalid,
  output logic                   o_m0_arready,
  output logic [`MEM_DATA_W-1:0] o_m0_rdata,
  output mem_pkg::axi_resp_e     o_m0_rresp,
  output logic                   o_m0_rvalid,
  input  logic                   i_m0_rready,
  // Master 1
  input  logic [`MEM_ID_W-1:0]   i_m1_awid,
  input  logic [`MEM_ADDR_W-1:0] i_m1_awaddr,
  input  logic                   i_m1_awvalid,
  output logic                   o_m1_awready,
  input  logic [`MEM_DATA_W-1:0] i_m1_wdata,
  input  logic [`MEM_STRB_W-1:0] i_m1_wstrb,
  input  logic                   i_m1_wvalid,
  output logic                   o_m1_wready,
  output mem_pkg::axi_resp_e     o_m1_bresp,
  output logic                   o_m1_bvalid,
  input  logic                   i_m1_bready,
  input  logic [`MEM_ID_W-1:0]   i_m1_arid,
  input  logic [`MEM_ADDR_W-1:0] i_m1_araddr,
  input  logic                   i_m1_arvalid,
  output logic                   o_m1_arready,
  output logic [`MEM_DATA_W-1:0] o_m1_rdata,
  output mem_pkg::axi_resp_e     o_m1_rresp,
  output logic                   o_m1_rvalid,
  input  logic                   i_m1_rready,
  // Slave
  output logic [`MEM_ID_W-1:0]   o_s_awid,
  output logic [`MEM_ADDR_W-1:0] o_s_awaddr,
  output logic                   o_s_awvalid,
  input  logic                   i_s_awready,
  output logic [`MEM_DATA_W-1:0] o_s_wdata,
  output logic [`MEM_STRB_W-1:0] o_s_wstrb,
  output logic                   o_s_wvalid,
  input  logic                   i_s_wready,
  input  logic [`MEM_ID_W-1:0]   i_s_bid,
  input  mem_pkg::axi_resp_e     i_s_bresp,
  input  logic                   i_s_bvalid,
  output logic                   o_s_bready,
  output logic [`MEM_ID_W-1:0]   o_s_arid,
  output logic [`MEM_ADDR_W-1:0] o_s_araddr,
  output logic                   o_s_arvalid,
  input  logic                   i_s_arready,
  input  logic [`MEM_ID_W-1:0]   i_s_rid,
  input  logic [`MEM_DATA_W-1:0] i_s_rdata,
  input  mem_pkg::axi_resp_e     i_s_rresp,
  input  logic                   i_s_rlast,
  input  logic                   i_s_rvalid,
  output logic                   o_s_rready
);

  mem_pkg::master_e      grant_q, sel;
  logic                  open_q, open_fire, close_fire;
  logic                  req0, req1, m1_sel;
  logic [`MEM_ID_W-1:0]  exp_id;

  assign req0 = i_m0_arvalid | i_m0_awvalid;
  assign req1 = i_m1_arvalid | i_m1_awvalid;

  // Last-served master loses a tie
  always_comb begin
    if (open_q) begin
      sel = grant_q;
    end else if (req1 && (!req0 || grant_q == mem_pkg::M_FETCH)) begin
      sel = mem_pkg::M_LSU;
    end else begin
      sel = mem_pkg::M_FETCH;
    end
  end

  assign open_fire  = (o_s_arvalid & i_s_arready) | (o_s_awvalid & i_s_awready);
  assign close_fire = (i_s_rvalid & o_s_rready) | (i_s_bvalid & o_s_bready);

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      open_q  <= 1'b0;
      grant_q <= mem_pkg::M_LSU;
    end else if (open_fire) begin
      open_q  <= 1'b1;
      grant_q <= sel;
    end else if (close_fire) begin
      open_q <= 1'b0;
    end
  end

  // --------------------
  // Request path, address valids blocked while open
  assign m1_sel      = sel == mem_pkg::M_LSU;
  assign o_s_awvalid = !open_q & (m1_sel ? i_m1_awvalid : i_m0_awvalid);
  assign o_s_awid    = m1_sel ? i_m1_awid : i_m0_awid;
  assign o_s_awaddr  = m1_sel ? i_m1_awaddr : i_m0_awaddr;
  assign o_s_wvalid  = m1_sel ? i_m1_wvalid : i_m0_wvalid;
  assign o_s_wdata   = m1_sel ? i_m1_wdata : i_m0_wdata;
  assign o_s_wstrb   = m1_sel ? i_m1_wstrb : i_m0_wstrb;
  assign o_s_bready  = m1_sel ? i_m1_bready : i_m0_bready;
  assign o_s_arvalid = !open_q & (m1_sel ? i_m1_arvalid : i_m0_arvalid);
  assign o_s_arid    = m1_sel ? i_m1_arid : i_m0_arid;
  assign o_s_araddr  = m1_sel ? i_m1_araddr : i_m0_araddr;
  assign o_s_rready  = m1_sel ? i_m1_rready : i_m0_rready;

  // --------------------
  // Response path
  assign o_m0_awready = !m1_sel & !open_q & i_s_awready;
  assign o_m0_arready = !m1_sel & !open_q & i_s_arready;
  assign o_m0_wready  = !m1_sel & i_s_wready;
  assign o_m0_bvalid  = !m1_sel & i_s_bvalid;
  assign o_m0_rvalid  = !m1_sel & i_s_rvalid;
  assign o_m1_awready = m1_sel & !open_q & i_s_awready;
  assign o_m1_arready = m1_sel & !open_q & i_s_arready;
  assign o_m1_wready  = m1_sel & i_s_wready;
  assign o_m1_bvalid  = m1_sel & i_s_bvalid;
  assign o_m1_rvalid  = m1_sel & i_s_rvalid;
  assign o_m0_bresp   = i_s_bresp;
  assign o_m1_bresp   = i_s_bresp;
  assign o_m0_rdata   = i_s_rdata;
  assign o_m1_rdata   = i_s_rdata;
  assign o_m0_rresp   = i_s_rresp;
  assign o_m1_rresp   = i_s_rresp;

  assign exp_id = (grant_q == mem_pkg::M_LSU) ? `MEM_ID_LSU : `MEM_ID_FETCH;

  // Slave responds only inside an open grant
  assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    (i_s_rvalid || i_s_bvalid) |-> open_q);
  // Returned IDs belong to the granted master
  assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_s_rvalid |-> i_s_rlast && i_s_rid == exp_id);
  assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_s_bvalid |-> i_s_bid == exp_id);

endmodule

//--- hw/axi_sram.sv
// AXI4 single-beat SRAM slave
`timescale 1ns/1ps
`include "mem_params.svh"

module axi_sram (
  input  logic                   i_aclk,
  input  logic                   i_arst_n,
  // Write address
  input  logic [`MEM_ID_W-1:0]   i_awid,
  input  logic [`MEM_ADDR_W-1:0] i_awaddr,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  // Write data
  input  logic [`MEM_DATA_W-1:0] i_wdata,
  input  logic [`MEM_STRB_W-1:0] i_wstrb,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  // Write response
  output logic [`MEM_ID_W-1:0]   o_bid,
  output mem_pkg::axi_resp_e     o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  // Read address
  input  logic [`MEM_ID_W-1:0]   i_arid,
  input  logic [`MEM_ADDR_W-1:0] i_araddr,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  // Read data
  output logic [`MEM_ID_W-1:0]   o_rid,
  output logic [`MEM_DATA_W-1:0] o_rdata,
  output mem_pkg::axi_resp_e     o_rresp,
  output logic                   o_rlast,
  output logic                   o_rvalid,
  input  logic                   i_rready
);

  localparam int IDX_W = $clog2(`MEM_DEPTH);

  typedef enum logic {R_IDLE, R_READ} rd_state_e;
  typedef enum logic [1:0] {W_IDLE, W_WRITE, W_RESP} wr_state_e;

  rd_state_e              rd_state;
  wr_state_e              wr_state;
  logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];
  logic [`MEM_ADDR_W-1:0] awaddr_q;
  logic                   bvalid_q;
  logic                   ar_fire, r_fire, aw_fire, w_fire, b_fire;
  logic                   ar_in_range, aw_in_range;

  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;
  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;

  // Doubleword index below depth
  assign ar_in_range = i_araddr[`MEM_ADDR_W-1:3] < (`MEM_ADDR_W-3)'(`MEM_DEPTH);
  assign aw_in_range = awaddr_q[`MEM_ADDR_W-1:3] < (`MEM_ADDR_W-3)'(`MEM_DEPTH);

  // --------------------
  // Read side
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_state <= R_IDLE;
    end else begin
      case (rd_state)
        R_IDLE: if (ar_fire) rd_state <= R_READ;
        R_READ: if (r_fire) rd_state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      o_rid   <= i_arid;
      o_rdata <= ar_in_range ? mem[i_araddr[IDX_W+2:3]] : '0;
      o_rresp <= ar_in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
    end
  end

  assign o_arready = rd_state == R_IDLE;
  assign o_rvalid  = rd_state == R_READ;
  assign o_rlast   = 1'b1;

  // --------------------
  // Write side
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_state <= W_IDLE;
      bvalid_q <= 1'b0;
    end else begin
      case (wr_state)
        W_IDLE:  if (aw_fire) wr_state <= W_WRITE;
        W_WRITE: if (w_fire) wr_state <= W_RESP;
        W_RESP:  if (b_fire) wr_state <= W_IDLE;
        default: wr_state <= W_IDLE;
      endcase
      if (w_fire) begin
        bvalid_q <= 1'b1;
      end else if (b_fire) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      awaddr_q <= i_awaddr;
      o_bid    <= i_awid;
    end
    if (w_fire) begin
      o_bresp <= aw_in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
      for (int b = 0; b < `MEM_STRB_W; b++) begin
        if (aw_in_range && i_wstrb[b]) begin
          mem[awaddr_q[IDX_W+2:3]][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  assign o_awready = wr_state == W_IDLE;
  assign o_wready  = wr_state == W_WRITE;
  assign o_bvalid  = bvalid_q;

  // Read response held until taken
  assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));
  assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    wr_state == W_IDLE |-> !o_bvalid);

endmodule

//--- hw/mem_pkg.sv
// Memory subsystem types
package mem_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axi_resp_e;

  // Owner of the arbiter grant
  typedef enum logic {
    M_FETCH = 1'b0,
    M_LSU   = 1'b1
  } master_e;

endpackage

//--- include/mem_params.svh
// Memory subsystem parameters
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

`define MEM_DATA_W   64
`define MEM_ADDR_W   32
`define MEM_STRB_W   8
`define MEM_ID_W     4

// Doublewords, so byte addresses 0 to 2047
`define MEM_DEPTH    256

// Fixed AXI IDs of the two masters
`define MEM_ID_FETCH 4'd0
`define MEM_ID_LSU   4'd1

`endif
